/* hw/tti_defs.svh */
// TTI queue parameters

`ifndef TTI_DEFS_SVH
`define TTI_DEFS_SVH

// Width of one queue word
`define TTI_DATA_WIDTH 32

// Words held by each data queue
`define TTI_FIFO_DEPTH 8

// Threshold and fill level width, wide enough for a full queue
`define TTI_THLD_WIDTH 4

`endif

/* hw/tti_pkg.sv */
// TTI shared types

`include "tti_defs.svh"

package tti_pkg;

    // Handler state
    typedef enum logic [0:0] {
        MODE_NORMAL   = 1'b0,
        MODE_RECOVERY = 1'b1
    } tti_mode_e;

    // Controller push into RX queue
    typedef struct packed {
        logic                       valid;
        logic [`TTI_DATA_WIDTH-1:0] data;
    } tti_ctl_wr_req_t;

    // RX status back to controller
    typedef struct packed {
        logic ready;
        logic full;
        logic empty;
        logic thld_trig;
    } tti_ctl_wr_rsp_t;

    // TX pop side toward controller
    typedef struct packed {
        logic                       valid;
        logic [`TTI_DATA_WIDTH-1:0] data;
        logic                       full;
        logic                       empty;
        logic                       thld_trig;
    } tti_ctl_rd_rsp_t;

    // Software push into TX queue
    typedef struct packed {
        logic                       req;
        logic [`TTI_DATA_WIDTH-1:0] data;
    } tti_csr_wr_req_t;

    // Software pop from RX queue
    typedef struct packed {
        logic                       ack;
        logic [`TTI_DATA_WIDTH-1:0] data;
    } tti_csr_rd_rsp_t;

endpackage

/* hw/tti_fifo.sv */
// Synchronous show-ahead FIFO

`timescale 1ns/100ps

`include "tti_defs.svh"

module tti_fifo #(
    parameter int unsigned Depth = `TTI_FIFO_DEPTH
) (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       push_i,
    input  logic [`TTI_DATA_WIDTH-1:0] push_data_i,
    input  logic                       pop_i,
    output logic [`TTI_DATA_WIDTH-1:0] head_o,
    output logic [`TTI_THLD_WIDTH-1:0] count_o,
    output logic                       full_o,
    output logic                       empty_o
);

    localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
    localparam logic [PtrWidth-1:0] LastPtr = PtrWidth'(Depth - 1);
    localparam logic [`TTI_THLD_WIDTH-1:0] FullCount = `TTI_THLD_WIDTH'(Depth);

    logic [`TTI_DATA_WIDTH-1:0] mem_q [Depth];
    logic [PtrWidth-1:0]        wr_ptr_q;
    logic [PtrWidth-1:0]        rd_ptr_q;
    logic [`TTI_THLD_WIDTH-1:0] count_q;

    // Storage
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    // Pointers and fill count
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == LastPtr) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == LastPtr) ? '0 : rd_ptr_q + 1'b1;
            end
            // Push with pop leaves the level alone, also when full
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    assign head_o  = mem_q[rd_ptr_q];
    assign count_o = count_q;
    assign full_o  = (count_q == FullCount);
    assign empty_o = (count_q == '0);

    a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
        push_i && full_o |-> pop_i)
        else $error("push into full FIFO without pop");

    a_no_underflow: assert property (@(posedge clk_i) disable iff (reset_i)
        !(pop_i && empty_o))
        else $error("pop from empty FIFO");

endmodule

/* hw/tti_rx_queue.sv */
// TTI RX data queue

`timescale 1ns/100ps

`include "tti_defs.svh"

module tti_rx_queue (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  tti_pkg::tti_ctl_wr_req_t   ctl_i,
    output tti_pkg::tti_ctl_wr_rsp_t   ctl_o,
    input  logic                       csr_req_i,
    output tti_pkg::tti_csr_rd_rsp_t   csr_o,
    input  logic [`TTI_THLD_WIDTH-1:0] thld_i
);

    logic                       push;
    logic                       pop;
    logic [`TTI_DATA_WIDTH-1:0] head;
    logic [`TTI_THLD_WIDTH-1:0] count;
    logic                       full;
    logic                       empty;

    // Controller writes while there is room
    assign push = ctl_i.valid & ~full;

    // Software pops the head when something is queued
    assign pop = csr_req_i & ~empty;

    tti_fifo u_fifo (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .push_i      (push),
        .push_data_i (ctl_i.data),
        .pop_i       (pop),
        .head_o      (head),
        .count_o     (count),
        .full_o      (full),
        .empty_o     (empty)
    );

    assign ctl_o.ready     = ~full;
    assign ctl_o.full      = full;
    assign ctl_o.empty     = empty;
    // Zero threshold disables the trigger
    assign ctl_o.thld_trig = (thld_i != '0) && (count >= thld_i);

    assign csr_o.ack  = pop;
    assign csr_o.data = head;

endmodule

/* hw/tti_tx_queue.sv */
// TTI TX data queue

`timescale 1ns/100ps

`include "tti_defs.svh"

module tti_tx_queue (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  tti_pkg::tti_csr_wr_req_t   csr_i,
    output logic                       csr_ack_o,
    input  logic                       ctl_rready_i,
    output tti_pkg::tti_ctl_rd_rsp_t   ctl_o,
    input  logic [`TTI_THLD_WIDTH-1:0] thld_i
);

    logic                       push;
    logic                       pop;
    logic [`TTI_DATA_WIDTH-1:0] head;
    logic [`TTI_THLD_WIDTH-1:0] count;
    logic                       full;
    logic                       empty;

    // Software push is acked only with room left
    assign push = csr_i.req & ~full;

    // Controller takes the head on valid and ready
    assign pop = ctl_rready_i & ~empty;

    tti_fifo u_fifo (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .push_i      (push),
        .push_data_i (csr_i.data),
        .pop_i       (pop),
        .head_o      (head),
        .count_o     (count),
        .full_o      (full),
        .empty_o     (empty)
    );

    assign csr_ack_o = push;

    assign ctl_o.valid     = ~empty;
    assign ctl_o.data      = head;
    assign ctl_o.full      = full;
    assign ctl_o.empty     = empty;
    // Same trigger rule as RX
    assign ctl_o.thld_trig = (thld_i != '0) && (count >= thld_i);

endmodule

/* hw/tti_recovery_mux.sv */
// TTI recovery mode isolation

`timescale 1ns/100ps

module tti_recovery_mux (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic                     recovery_en_i,

    // Controller side of RX queue
    input  tti_pkg::tti_ctl_wr_req_t ctl_rx_ext_i,
    output tti_pkg::tti_ctl_wr_req_t ctl_rx_q_o,
    input  tti_pkg::tti_ctl_wr_rsp_t ctl_rx_q_i,
    output tti_pkg::tti_ctl_wr_rsp_t ctl_rx_ext_o,

    // Controller side of TX queue
    input  logic                     ctl_tx_rready_ext_i,
    output logic                     ctl_tx_rready_q_o,
    input  tti_pkg::tti_ctl_rd_rsp_t ctl_tx_q_i,
    output tti_pkg::tti_ctl_rd_rsp_t ctl_tx_ext_o,

    // Software side of RX queue
    input  logic                     csr_rx_req_ext_i,
    output logic                     csr_rx_req_q_o,
    input  tti_pkg::tti_csr_rd_rsp_t csr_rx_q_i,
    output tti_pkg::tti_csr_rd_rsp_t csr_rx_ext_o,

    // Software side of TX queue
    input  tti_pkg::tti_csr_wr_req_t csr_tx_ext_i,
    output tti_pkg::tti_csr_wr_req_t csr_tx_q_o,
    input  logic                     csr_tx_ack_q_i,
    output logic                     csr_tx_ack_ext_o
);

    import tti_pkg::*;

    tti_mode_e mode_q;
    logic      in_recovery;

    // Mode follows the enable one cycle later
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mode_q <= MODE_NORMAL;
        end else begin
            mode_q <= recovery_en_i ? MODE_RECOVERY : MODE_NORMAL;
        end
    end

    assign in_recovery = (mode_q == MODE_RECOVERY);

    // Requests toward the queues
    always_comb begin
        if (in_recovery) begin
            ctl_rx_q_o        = '0;
            ctl_tx_rready_q_o = 1'b0;
            csr_rx_req_q_o    = 1'b0;
            csr_tx_q_o        = '0;
        end else begin
            ctl_rx_q_o        = ctl_rx_ext_i;
            ctl_tx_rready_q_o = ctl_tx_rready_ext_i;
            csr_rx_req_q_o    = csr_rx_req_ext_i;
            csr_tx_q_o        = csr_tx_ext_i;
        end
    end

    // Responses toward controller and software
    always_comb begin
        if (in_recovery) begin
            ctl_rx_ext_o     = '0;
            ctl_tx_ext_o     = '0;
            csr_rx_ext_o     = '0;
            csr_tx_ack_ext_o = 1'b0;
        end else begin
            ctl_rx_ext_o     = ctl_rx_q_i;
            ctl_tx_ext_o     = ctl_tx_q_i;
            csr_rx_ext_o     = csr_rx_q_i;
            csr_tx_ack_ext_o = csr_tx_ack_q_i;
        end
    end

    // Isolated queues raise no ack
    a_isolated: assert property (@(posedge clk_i) disable iff (reset_i)
        in_recovery |-> !(csr_rx_q_i.ack || csr_tx_ack_q_i))
        else $error("queue ack active in recovery mode");

    // Fill state held across an isolated cycle
    a_frozen: assert property (@(posedge clk_i) disable iff (reset_i)
        in_recovery |=> $stable({ctl_rx_q_i.full, ctl_rx_q_i.empty,
                                 ctl_tx_q_i.full, ctl_tx_q_i.empty}))
        else $error("queue fill state changed in recovery mode");

endmodule

/* hw/recovery_handler.sv */
// TTI recovery handler

`timescale 1ns/100ps

`include "tti_defs.svh"

module recovery_handler (
    input  logic                       clk_i,
    input  logic                       reset_i,

    // Controller
    input  tti_pkg::tti_ctl_wr_req_t   ctl_rx_i,
    output tti_pkg::tti_ctl_wr_rsp_t   ctl_rx_o,
    input  logic                       ctl_tx_rready_i,
    output tti_pkg::tti_ctl_rd_rsp_t   ctl_tx_o,

    // Software
    input  logic                       csr_rx_req_i,
    output tti_pkg::tti_csr_rd_rsp_t   csr_rx_o,
    input  tti_pkg::tti_csr_wr_req_t   csr_tx_i,
    output logic                       csr_tx_ack_o,
    input  logic [`TTI_THLD_WIDTH-1:0] csr_rx_thld_i,
    input  logic [`TTI_THLD_WIDTH-1:0] csr_tx_thld_i,

    input  logic                       recovery_en_i
);

    import tti_pkg::*;

    // Queue-side copies behind the mux
    tti_ctl_wr_req_t ctl_rx_q;
    tti_ctl_wr_rsp_t ctl_rx_rsp_q;
    logic            ctl_tx_rready_q;
    tti_ctl_rd_rsp_t ctl_tx_rsp_q;
    logic            csr_rx_req_q;
    tti_csr_rd_rsp_t csr_rx_rsp_q;
    tti_csr_wr_req_t csr_tx_q;
    logic            csr_tx_ack_q;

    tti_rx_queue u_rx_queue (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .ctl_i     (ctl_rx_q),
        .ctl_o     (ctl_rx_rsp_q),
        .csr_req_i (csr_rx_req_q),
        .csr_o     (csr_rx_rsp_q),
        .thld_i    (csr_rx_thld_i)
    );

    tti_tx_queue u_tx_queue (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .csr_i        (csr_tx_q),
        .csr_ack_o    (csr_tx_ack_q),
        .ctl_rready_i (ctl_tx_rready_q),
        .ctl_o        (ctl_tx_rsp_q),
        .thld_i       (csr_tx_thld_i)
    );

    tti_recovery_mux u_recovery_mux (
        .clk_i               (clk_i),
        .reset_i             (reset_i),
        .recovery_en_i       (recovery_en_i),
        .ctl_rx_ext_i        (ctl_rx_i),
        .ctl_rx_q_o          (ctl_rx_q),
        .ctl_rx_q_i          (ctl_rx_rsp_q),
        .ctl_rx_ext_o        (ctl_rx_o),
        .ctl_tx_rready_ext_i (ctl_tx_rready_i),
        .ctl_tx_rready_q_o   (ctl_tx_rready_q),
        .ctl_tx_q_i          (ctl_tx_rsp_q),
        .ctl_tx_ext_o        (ctl_tx_o),
        .csr_rx_req_ext_i    (csr_rx_req_i),
        .csr_rx_req_q_o      (csr_rx_req_q),
        .csr_rx_q_i          (csr_rx_rsp_q),
        .csr_rx_ext_o        (csr_rx_o),
        .csr_tx_ext_i        (csr_tx_i),
        .csr_tx_q_o          (csr_tx_q),
        .csr_tx_ack_q_i      (csr_tx_ack_q),
        .csr_tx_ack_ext_o    (csr_tx_ack_o)
    );

endmodule

/* bench/tb_recovery_handler.sv */
// Recovery handler testbench

`timescale 1ns/100ps

`include "tti_defs.svh"

module tb_recovery_handler;

    import tti_pkg::*;

    localparam int Depth = `TTI_FIFO_DEPTH;
    localparam int StimCycles = 10 + 2 + 60 + 60 + (Depth + 8) + 4 * (2 * Depth + 5)
                                + (Depth / 2 + 23) + 4 * (Depth + 4);
    localparam int TimeoutCycles = StimCycles * 2 + 200;

    logic                       clk_i;
    logic                       reset_i;
    tti_ctl_wr_req_t            ctl_rx_i;
    tti_ctl_wr_rsp_t            ctl_rx_o;
    logic                       ctl_tx_rready_i;
    tti_ctl_rd_rsp_t            ctl_tx_o;
    logic                       csr_rx_req_i;
    tti_csr_rd_rsp_t            csr_rx_o;
    tti_csr_wr_req_t            csr_tx_i;
    logic                       csr_tx_ack_o;
    logic [`TTI_THLD_WIDTH-1:0] csr_rx_thld_i;
    logic [`TTI_THLD_WIDTH-1:0] csr_tx_thld_i;
    logic                       recovery_en_i;

    // Reference queues and their registered views
    logic [`TTI_DATA_WIDTH-1:0] rx_model [$];
    logic [`TTI_DATA_WIDTH-1:0] tx_model [$];
    logic [`TTI_DATA_WIDTH-1:0] rx_head;
    logic [`TTI_DATA_WIDTH-1:0] tx_head;
    int                         rx_size;
    int                         tx_size;
    logic                       exp_rec;

    integer seed = 11;
    int     fail_count = 0;
    int     fail_mark = 0;
    int     tests_run = 0;
    int     tests_bad = 0;

    recovery_handler u_dut (.*);

    initial clk_i = 1'b0;
    always #20 clk_i = ~clk_i;

    // Track every observed transfer
    always @(posedge clk_i) begin
        if (reset_i) begin
            rx_model.delete();
            tx_model.delete();
        end else begin
            if (ctl_rx_i.valid && ctl_rx_o.ready) rx_model.push_back(ctl_rx_i.data);
            if (csr_rx_req_i && csr_rx_o.ack) void'(rx_model.pop_front());
            if (csr_tx_i.req && csr_tx_ack_o) tx_model.push_back(csr_tx_i.data);
            if (ctl_tx_o.valid && ctl_tx_rready_i) void'(tx_model.pop_front());
        end
        rx_size <= rx_model.size();
        tx_size <= tx_model.size();
        rx_head <= (rx_model.size() != 0) ? rx_model[0] : '0;
        tx_head <= (tx_model.size() != 0) ? tx_model[0] : '0;
        exp_rec <= reset_i ? 1'b0 : recovery_en_i;
    end

    task automatic report_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        fail_count++;
    endtask

    // Mode 2 always, mode 1 random, mode 0 off
    function automatic logic pick(input int mode);
        return (mode == 2) || (mode == 1 && ($random(seed) & 1));
    endfunction

    a_rx_status: assert property (@(posedge clk_i) disable iff (reset_i)
        !exp_rec |-> (ctl_rx_o.ready == (rx_size != Depth)) && (ctl_rx_o.full == (rx_size == Depth))
        && (ctl_rx_o.empty == (rx_size == 0)) && (csr_rx_o.ack == (csr_rx_req_i && rx_size != 0))
        && (ctl_rx_o.thld_trig == (csr_rx_thld_i != 0 && rx_size >= csr_rx_thld_i)))
        else report_error("RX status, ack or trigger differs from model");
    a_rx_data: assert property (@(posedge clk_i) disable iff (reset_i)
        csr_rx_o.ack |-> csr_rx_o.data == rx_head)
        else report_error("RX pop data out of order");
    a_tx_status: assert property (@(posedge clk_i) disable iff (reset_i)
        !exp_rec |-> (ctl_tx_o.valid == (tx_size != 0)) && (ctl_tx_o.full == (tx_size == Depth))
        && (ctl_tx_o.empty == (tx_size == 0)) && (csr_tx_ack_o == (csr_tx_i.req && tx_size != Depth))
        && (ctl_tx_o.thld_trig == (csr_tx_thld_i != 0 && tx_size >= csr_tx_thld_i)))
        else report_error("TX status, ack or trigger differs from model");
    a_tx_data: assert property (@(posedge clk_i) disable iff (reset_i)
        ctl_tx_o.valid |-> ctl_tx_o.data == tx_head)
        else report_error("TX pop data out of order");
    a_tx_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        ctl_tx_o.valid && !ctl_tx_rready_i && !recovery_en_i |=> $stable(ctl_tx_o.data))
        else report_error("TX data changed while stalled");
    a_isolated: assert property (@(posedge clk_i) disable iff (reset_i)
        exp_rec |-> ctl_rx_o == '0 && ctl_tx_o == '0 && csr_rx_o == '0 && !csr_tx_ack_o)
        else report_error("outputs not zero in recovery mode");

    task automatic run_traffic(input int cycles, input int rx_push, input int rx_pop,
                               input int tx_push, input int tx_pop);
        repeat (cycles) begin
            @(posedge clk_i);
            // Words are held until accepted
            if (!ctl_rx_i.valid || ctl_rx_o.ready) begin
                ctl_rx_i.valid <= pick(rx_push);
                ctl_rx_i.data  <= $random(seed);
            end
            if (!csr_tx_i.req || csr_tx_ack_o) begin
                csr_tx_i.req  <= pick(tx_push);
                csr_tx_i.data <= $random(seed);
            end
            csr_rx_req_i    <= pick(rx_pop);
            ctl_tx_rready_i <= pick(tx_pop);
        end
    endtask

    task automatic drain();
        while (rx_size != 0 || tx_size != 0 || ctl_rx_i.valid || csr_tx_i.req) begin
            run_traffic(1, 0, 2, 0, 2);
        end
        run_traffic(1, 0, 0, 0, 0);
    endtask

    task automatic finish_test(input string name);
        @(negedge clk_i);
        tests_run++;
        if (fail_count != fail_mark) begin
            tests_bad++;
            $display("%s: %0d errors", name, fail_count - fail_mark);
        end else begin
            $display("%s: ok", name);
        end
        fail_mark = fail_count;
    endtask

    initial begin
        reset_i         <= 1'b1;
        ctl_rx_i        <= '0;
        ctl_tx_rready_i <= 1'b0;
        csr_rx_req_i    <= 1'b0;
        csr_tx_i        <= '0;
        csr_rx_thld_i   <= '0;
        csr_tx_thld_i   <= '0;
        recovery_en_i   <= 1'b0;
        repeat (10) @(posedge clk_i);
        reset_i <= 1'b0;
        run_traffic(2, 0, 0, 0, 0);
        finish_test("reset state");
        run_traffic(60, 1, 1, 0, 0);
        drain();
        finish_test("rx ordering");
        run_traffic(60, 0, 0, 1, 1);
        drain();
        finish_test("tx ordering with stalls");
        run_traffic(Depth + 8, 2, 0, 2, 0);
        drain();
        finish_test("back-pressure");
        for (int i = 0; i < 4; i++) begin
            @(posedge clk_i);
            // Last round keeps the threshold at zero
            csr_rx_thld_i <= (i == 3) ? '0 : `TTI_THLD_WIDTH'(1 + $unsigned($random(seed)) % Depth);
            csr_tx_thld_i <= (i == 3) ? '0 : `TTI_THLD_WIDTH'(1 + $unsigned($random(seed)) % Depth);
            run_traffic(Depth, 2, 0, 2, 0);
            run_traffic(Depth + 4, 0, 2, 0, 2);
        end
        finish_test("thresholds");
        run_traffic(Depth / 2, 2, 0, 2, 0);
        @(posedge clk_i);
        recovery_en_i <= 1'b1;
        run_traffic(20, 1, 1, 1, 1);
        @(posedge clk_i);
        recovery_en_i <= 1'b0;
        run_traffic(1, 0, 0, 0, 0);
        drain();
        finish_test("recovery");
        $display("Summary: %0d tests, %0d with errors, %0d assertion failures",
                 tests_run, tests_bad, fail_count);
        if (fail_count == 0) $display("test passed");
        else $display("test failed");
        $finish;
    end

    initial begin
        repeat (TimeoutCycles) @(posedge clk_i);
        $display("Watchdog: simulation timed out after %0d cycles", TimeoutCycles);
        $display("test failed");
        $finish;
    end

endmodule

/* files.f */
+incdir+hw
hw/tti_pkg.sv
hw/tti_fifo.sv
hw/tti_rx_queue.sv
hw/tti_tx_queue.sv
hw/tti_recovery_mux.sv
hw/recovery_handler.sv
bench/tb_recovery_handler.sv

/* Bender.yml */
package:
  name: recovery_handler

sources:
  - include_dirs:
      - hw
    files:
      - hw/tti_pkg.sv
      - hw/tti_fifo.sv
      - hw/tti_rx_queue.sv
      - hw/tti_tx_queue.sv
      - hw/tti_recovery_mux.sv
      - hw/recovery_handler.sv
      - bench/tb_recovery_handler.sv
